/* sim.f */
rtl/ecc_pkg.sv
rtl/wb_pkg.sv
rtl/secded_39_32_enc.sv
rtl/secded_39_32_dec.sv
rtl/wb_bus_ecc_dec.sv
rtl/wb_sram.sv
rtl/wb_ecc_subsys.sv
verification/wb_ecc_props.sv
verification/tb_wb_ecc_subsys.sv

/* Makefile */
# Verilator flow for the SECDED Wishbone subsystem
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_wb_ecc_subsys
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_wb_ecc_subsys.sv */
// ********************
// testbench for the ECC Wishbone subsystem: LFSR stimulus, a shadow memory
// with its own encoder, error injection, counter model and a test report
// ********************

`timescale 1ns/1ps

module tb_wb_ecc_subsys;

  import ecc_pkg::*;
  import wb_pkg::*;

  localparam int Words      = 64;
  localparam int AckTimeout = 20;  // cycles allowed per access

  logic                   clk_i, rst_i, cyc_i, stb_i, we_i, ack_o;
  logic [WbAdrWidth-1:0]  adr_i;
  logic [WbSelWidth-1:0]  sel_i;
  logic [WbDataWidth-1:0] dat_i, dat_o;
  logic [EccParWidth-1:0] tgd_i, tgd_o, syndrome_o;
  ecc_err_e               err_o;
  logic [WbCntWidth-1:0]  corr_cnt_o, uncorr_cnt_o;

  logic [WbDataWidth-1:0] shadow [Words];     // expected memory contents
  logic [WbCntWidth-1:0]  m_corr, m_uncorr;   // expected counters
  logic [31:0]            lfsr_q;
  int                     checks, errors, test_err0;
  bit                     hung;               // an ack never came

  wb_ecc_subsys #(.MemAddrWidth(6)) UUT (
    .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i),
    .adr_i (adr_i), .sel_i (sel_i), .dat_i (dat_i), .tgd_i (tgd_i),
    .ack_o (ack_o), .dat_o (dat_o), .tgd_o (tgd_o),
    .syndrome_o (syndrome_o), .err_o (err_o),
    .corr_cnt_o (corr_cnt_o), .uncorr_cnt_o (uncorr_cnt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  // Galois LFSR, taps 32'h8020_0003, one step per bit
  function automatic logic next_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], next_bit()};
    end
    return r;
  endfunction

  // model encoder, check bit k is the masked parity
  function automatic logic [EccParWidth-1:0] enc_chk(logic [WbDataWidth-1:0] d);
    logic [EccParWidth-1:0] c;
    for (int k = 0; k < EccParWidth; k++) begin
      c[k] = ^(d & ecc_par_masks[k]);
    end
    return c;
  endfunction

  // H matrix column of codeword bit p
  function automatic logic [EccParWidth-1:0] col_of(int p);
    logic [EccParWidth-1:0] c;
    c = '0;
    if (p < EccDataWidth) begin
      for (int k = 0; k < EccParWidth; k++) c[k] = ecc_par_masks[k][p];
    end else begin
      c[p - EccDataWidth] = 1'b1;  // check bits are unit columns
    end
    return c;
  endfunction

  task automatic check_data(string name, logic [WbDataWidth-1:0] exp,
                            logic [WbDataWidth-1:0] act);
    checks++;
    if (!hung && act !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_chk(string name, logic [EccParWidth-1:0] exp,
                           logic [EccParWidth-1:0] act);
    checks++;
    if (!hung && act !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_err(string name, ecc_err_e exp, ecc_err_e act);
    checks++;
    if (!hung && act !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_count(string name, logic [WbCntWidth-1:0] exp,
                             logic [WbCntWidth-1:0] act);
    checks++;
    if (!hung && act !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // one classic cycle, called on a falling edge; ack must follow in one cycle
  task automatic bus_access(string name, logic we, logic [5:0] a, logic [WbSelWidth-1:0] sel,
                            logic [EccCodeWidth-1:0] code, output logic [WbDataWidth-1:0] rdat,
                            output logic [EccParWidth-1:0] rchk,
                            output logic [EccParWidth-1:0] syn, output ecc_err_e err);
    int   cycles;
    logic got;
    cycles = 0;
    got = 1'b0;
    rdat = '0;
    rchk = '0;
    syn = '0;
    err = ECC_OK;
    if (!hung) begin
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = {24'd0, a, 2'b00};  // word address into byte address
      sel_i = sel;
      dat_i = code[EccDataWidth-1:0];
      tgd_i = code[EccCodeWidth-1:EccDataWidth];
      while (!got && cycles < AckTimeout) begin
        @(negedge clk_i);
        cycles++;
        got = ack_o;
      end
      if (!got) begin
        hung = 1'b1;
        $display("timeout: %s received no ack within %0d cycles", name, AckTimeout);
      end else begin
        rdat = dat_o;  // strobe still held, status is valid here
        rchk = tgd_o;
        syn  = syndrome_o;
        err  = err_o;
        checks++;
        if (cycles != 1) begin
          errors++;
          $display("%s: ack arrived %0d cycles after the request instead of 1", name, cycles);
        end
        @(negedge clk_i);  // master samples ack on the rising edge in between
        checks++;
        if (ack_o !== 1'b0) begin
          errors++;
          $display("%s: a second ack arrived for the same request", name);
        end
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
    end
  endtask

  // write d with nflip injected bit flips and update the model
  task automatic write_word(string name, logic [5:0] a, logic [WbSelWidth-1:0] sel,
                            logic [WbDataWidth-1:0] d, int nflip);
    logic [EccCodeWidth-1:0] code;
    logic [EccParWidth-1:0]  exp_syn, syn, rchk;
    logic [WbDataWidth-1:0]  stored, rdat;
    ecc_err_e                err, exp_err;
    int                      p1, p2;
    code = {enc_chk(d), d};
    exp_syn = '0;
    exp_err = ECC_OK;
    stored = d;
    p1 = int'(rand_bits(6) % 39);
    p2 = p1;
    if (nflip > 0) begin
      code[p1] = ~code[p1];
      exp_syn = col_of(p1);
      exp_err = ECC_CORRECTED;
    end
    if (nflip > 1) begin
      while (p2 == p1) p2 = int'(rand_bits(6) % 39);
      code[p2] = ~code[p2];
      exp_syn = exp_syn ^ col_of(p2);
      exp_err = ECC_UNCORRECTABLE;
      stored = code[EccDataWidth-1:0];  // even syndrome, data kept as received
    end
    bus_access(name, 1'b1, a, sel, code, rdat, rchk, syn, err);
    check_chk(name, exp_syn, syn);
    check_err(name, exp_err, err);
    for (int b = 0; b < WbSelWidth; b++) begin
      if (sel[b]) shadow[a][b*8 +: 8] = stored[b*8 +: 8];
    end
    if (exp_err == ECC_CORRECTED && m_corr != 8'hFF) m_corr = m_corr + 8'd1;
    if (exp_err == ECC_UNCORRECTABLE && m_uncorr != 8'hFF) m_uncorr = m_uncorr + 8'd1;
  endtask

  task automatic read_check(string name, logic [5:0] a);
    logic [WbDataWidth-1:0] rdat, junk;
    logic [EccParWidth-1:0] rchk, syn;
    ecc_err_e               err;
    junk = rand_bits(32);
    // bad codeword on the write lines, status must stay quiet on a read
    bus_access(name, 1'b0, a, 4'hF, {~enc_chk(junk), junk}, rdat, rchk, syn, err);
    check_data(name, shadow[a], rdat);
    check_chk(name, enc_chk(shadow[a]), rchk);
    check_chk(name, '0, syn);
    check_err(name, ECC_OK, err);
  endtask

  task automatic end_test(string name);
    if (errors == test_err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin
    logic [5:0]             a;
    logic [5:0]             addrs [16];
    logic [WbDataWidth-1:0] d;
    lfsr_q = 32'h6057_3595;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i = 1'b0;
    adr_i = '0;
    sel_i = '0;
    dat_i = '0;
    tgd_i = '0;
    m_corr = '0;
    m_uncorr = '0;
    checks = 0;
    errors = 0;
    test_err0 = 0;
    hung = 1'b0;
    rst_i = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;

    // every word gets an address-derived value first
    for (int i = 0; i < Words; i++) begin
      a = 6'(i);
      write_word("fill", a, 4'hF, {a, 2'b10, ~a, 2'b01, a ^ 6'h15, 2'b11, ~a ^ 6'h2A, 2'b00}, 0);
    end
    for (int i = 0; i < 16; i++) begin
      addrs[i] = 6'(rand_bits(6));
      write_word($sformatf("clean_wr[%0d]", i), addrs[i], 4'hF, rand_bits(32), 0);
    end
    for (int i = 0; i < 16; i++) read_check($sformatf("clean_rd[%0d]", i), addrs[i]);
    end_test("clean_rw");

    for (int i = 0; i < 16; i++) begin
      a = 6'(rand_bits(6));
      write_word($sformatf("single[%0d]", i), a, 4'hF, rand_bits(32), 1);
      read_check($sformatf("single_rd[%0d]", i), a);
    end
    end_test("single_err");

    for (int i = 0; i < 16; i++) begin
      a = 6'(rand_bits(6));
      write_word($sformatf("double[%0d]", i), a, 4'hF, rand_bits(32), 2);
      read_check($sformatf("double_rd[%0d]", i), a);
    end
    end_test("double_err");

    for (int i = 0; i < 16; i++) begin
      a = 6'(rand_bits(6));
      d = rand_bits(32);
      write_word($sformatf("bytesel[%0d]", i), a, 4'(rand_bits(4)), d, 0);
      read_check($sformatf("bytesel_rd[%0d]", i), a);
    end
    end_test("byte_sel");

    for (int i = 0; i < 40; i++) begin
      a = 6'(rand_bits(6));
      d = rand_bits(32);
      write_word($sformatf("mixed[%0d]", i), a, 4'(rand_bits(4)), d, int'(rand_bits(2) % 3));
    end
    check_count("corr_cnt", m_corr, corr_cnt_o);
    check_count("uncorr_cnt", m_uncorr, uncorr_cnt_o);
    // alternate single and double errors until both counters hit the top
    for (int i = 0; i < 512; i++) begin
      a = 6'(rand_bits(6));
      write_word($sformatf("sat[%0d]", i), a, 4'hF, rand_bits(32), 1 + (i % 2));
    end
    check_count("corr_cnt_sat", m_corr, corr_cnt_o);
    check_count("uncorr_cnt_sat", m_uncorr, uncorr_cnt_o);
    rst_i = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    m_corr = '0;
    m_uncorr = '0;
    check_count("corr_cnt_rst", m_corr, corr_cnt_o);
    check_count("uncorr_cnt_rst", m_uncorr, uncorr_cnt_o);
    for (int i = 0; i < 8; i++) read_check($sformatf("kept_rd[%0d]", i), 6'(rand_bits(6)));
    end_test("counters");

    // strobe low for a while, then back-to-back accesses
    for (int c = 0; c < 6; c++) begin
      @(negedge clk_i);
      checks++;
      if (ack_o !== 1'b0) begin
        errors++;
        $display("idle cycle %0d: ack is high while stb is low", c);
      end
    end
    for (int i = 0; i < 8; i++) begin
      a = 6'(rand_bits(6));
      write_word($sformatf("b2b_wr[%0d]", i), a, 4'hF, rand_bits(32), 0);
      read_check($sformatf("b2b_rd[%0d]", i), a);
    end
    end_test("handshake");

    $display("checks %0d, errors %0d, timeout %0d", checks, errors, hung);
    if (errors == 0 && !hung) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verification/wb_ecc_props.sv */
// ********************
// concurrent checks on the ECC bridge, bound to wb_bus_ecc_dec
// covers the ack handshake, the status gating and the counters
// ********************

`timescale 1ns/1ps

module wb_ecc_props (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic                          cyc_i,
  input logic                          stb_i,
  input logic                          we_i,
  input logic                          ack_o,
  input ecc_pkg::ecc_err_e             err_o,
  input logic [wb_pkg::WbCntWidth-1:0] corr_cnt_o,
  input logic [wb_pkg::WbCntWidth-1:0] uncorr_cnt_o
);

  import ecc_pkg::*;

  // ack only answers a live request
  a_ack_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_o) |-> cyc_i && stb_i)
    else $error("ack rose without cyc and stb");

  a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |=> !ack_o)  // one cycle per request
    else $error("ack high for two cycles");

  a_err_gated: assert property (@(posedge clk_i) disable iff (rst_i)
    !(cyc_i && stb_i && we_i) |-> err_o == ECC_OK)
    else $error("err_o not OK without a write strobe");

  // counters only move up between resets
  a_corr_mono: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> corr_cnt_o >= $past(corr_cnt_o))
    else $error("corrected counter decreased");

  a_uncorr_mono: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> uncorr_cnt_o >= $past(uncorr_cnt_o))
    else $error("uncorrectable counter decreased");

endmodule

bind wb_bus_ecc_dec wb_ecc_props u_props (
  .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i),
  .ack_o (ack_o), .err_o (err_o), .corr_cnt_o (corr_cnt_o), .uncorr_cnt_o (uncorr_cnt_o)
);

/* rtl/wb_ecc_subsys.sv */
// ********************
// top level: ECC bridge in front of the Wishbone SRAM
// the master sees 39-bit codewords as dat plus tgd
// ********************

`timescale 1ns/1ps

module wb_ecc_subsys #(
  parameter int unsigned MemAddrWidth = 6  // memory depth, handed to the SRAM
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            cyc_i,
  input  logic                            stb_i,
  input  logic                            we_i,
  input  logic [wb_pkg::WbAdrWidth-1:0]   adr_i,
  input  logic [wb_pkg::WbSelWidth-1:0]   sel_i,
  input  logic [wb_pkg::WbDataWidth-1:0]  dat_i,
  input  logic [ecc_pkg::EccParWidth-1:0] tgd_i,   // write check bits
  output logic                            ack_o,
  output logic [wb_pkg::WbDataWidth-1:0]  dat_o,
  output logic [ecc_pkg::EccParWidth-1:0] tgd_o,   // read check bits
  output logic [ecc_pkg::EccParWidth-1:0] syndrome_o,
  output ecc_pkg::ecc_err_e               err_o,
  output logic [wb_pkg::WbCntWidth-1:0]   corr_cnt_o,
  output logic [wb_pkg::WbCntWidth-1:0]   uncorr_cnt_o
);

  import wb_pkg::*;

  // bridge to memory, same handshake without tags
  logic                   m_cyc, m_stb, m_we, m_ack;
  logic [WbAdrWidth-1:0]  m_adr;
  logic [WbSelWidth-1:0]  m_sel;
  logic [WbDataWidth-1:0] m_wdat;  // corrected write data
  logic [WbDataWidth-1:0] m_rdat;  // raw read data

  wb_bus_ecc_dec u_bridge (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cyc_i        (cyc_i),
    .stb_i        (stb_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .sel_i        (sel_i),
    .dat_i        (dat_i),
    .tgd_i        (tgd_i),
    .ack_o        (ack_o),
    .dat_o        (dat_o),
    .tgd_o        (tgd_o),
    .m_cyc_o      (m_cyc),
    .m_stb_o      (m_stb),
    .m_we_o       (m_we),
    .m_adr_o      (m_adr),
    .m_sel_o      (m_sel),
    .m_dat_o      (m_wdat),
    .m_ack_i      (m_ack),
    .m_dat_i      (m_rdat),
    .syndrome_o   (syndrome_o),
    .err_o        (err_o),
    .corr_cnt_o   (corr_cnt_o),
    .uncorr_cnt_o (uncorr_cnt_o)
  );

  wb_sram #(
    .MemAddrWidth (MemAddrWidth)
  ) u_sram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (m_cyc),
    .stb_i (m_stb),
    .we_i  (m_we),
    .adr_i (m_adr),
    .sel_i (m_sel),
    .dat_i (m_wdat),
    .ack_o (m_ack),
    .dat_o (m_rdat)
  );

endmodule

/* rtl/wb_sram.sv */
// ********************
// word-addressed Wishbone classic SRAM slave with byte selects;
// ack is registered and lasts one cycle per request
// ********************

`timescale 1ns/1ps

module wb_sram #(
  parameter int unsigned MemAddrWidth = 6  // log2 of the word count
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           cyc_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [wb_pkg::WbAdrWidth-1:0]  adr_i,   // byte address
  input  logic [wb_pkg::WbSelWidth-1:0]  sel_i,
  input  logic [wb_pkg::WbDataWidth-1:0] dat_i,
  output logic                           ack_o,
  output logic [wb_pkg::WbDataWidth-1:0] dat_o
);

  import wb_pkg::*;

  localparam int unsigned Words = 2 ** MemAddrWidth;

  logic [WbDataWidth-1:0]  mem [Words];  // storage, contents survive reset
  logic [MemAddrWidth-1:0] word_adr;
  wb_slv_state_e           state_q, state_d;
  logic                    req;          // new request accepted this cycle

  assign word_adr = adr_i[MemAddrWidth+1:2];  // drop byte offset
  assign req      = cyc_i & stb_i & (state_q == S_IDLE);

  // S_ACK always falls back to idle, a held request waits one cycle
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (cyc_i && stb_i) state_d = S_ACK;
      S_ACK:   state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ack_o = (state_q == S_ACK);

  // write and read both land on the edge that raises ack
  always_ff @(posedge clk_i) begin
    if (req) begin
      dat_o <= mem[word_adr];  // old contents on a read
      if (we_i) begin
        for (int b = 0; b < WbSelWidth; b++) begin
          if (sel_i[b]) mem[word_adr][b*8 +: 8] <= dat_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* rtl/wb_bus_ecc_dec.sv */
// ********************
// Wishbone classic ECC bridge: decodes write codewords from dat/tgd,
// encodes read data back onto tgd and counts corrected and failed writes
// ********************

`timescale 1ns/1ps

module wb_bus_ecc_dec (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // master side, check bits on the data tag
  input  logic                            cyc_i,
  input  logic                            stb_i,
  input  logic                            we_i,
  input  logic [wb_pkg::WbAdrWidth-1:0]   adr_i,
  input  logic [wb_pkg::WbSelWidth-1:0]   sel_i,
  input  logic [wb_pkg::WbDataWidth-1:0]  dat_i,
  input  logic [ecc_pkg::EccParWidth-1:0] tgd_i,
  output logic                            ack_o,
  output logic [wb_pkg::WbDataWidth-1:0]  dat_o,
  output logic [ecc_pkg::EccParWidth-1:0] tgd_o,
  // memory side, plain data
  output logic                            m_cyc_o,
  output logic                            m_stb_o,
  output logic                            m_we_o,
  output logic [wb_pkg::WbAdrWidth-1:0]   m_adr_o,
  output logic [wb_pkg::WbSelWidth-1:0]   m_sel_o,
  output logic [wb_pkg::WbDataWidth-1:0]  m_dat_o,
  input  logic                            m_ack_i,
  input  logic [wb_pkg::WbDataWidth-1:0]  m_dat_i,
  // write status
  output logic [ecc_pkg::EccParWidth-1:0] syndrome_o,
  output ecc_pkg::ecc_err_e               err_o,
  output logic [wb_pkg::WbCntWidth-1:0]   corr_cnt_o,
  output logic [wb_pkg::WbCntWidth-1:0]   uncorr_cnt_o
);

  import ecc_pkg::*;
  import wb_pkg::*;

  localparam logic [WbCntWidth-1:0] CntMax = '1;  // saturation point

  logic [EccCodeWidth-1:0] rd_code;   // encoded read word
  logic [EccParWidth-1:0]  dec_syn;   // raw decoder syndrome
  ecc_err_e                dec_err;   // raw decoder class
  logic                    wr_stb;    // write strobe toward the memory

  assign wr_stb = cyc_i & stb_i & we_i;

  // handshake and address go through untouched, the bridge adds no cycles
  assign m_cyc_o = cyc_i;
  assign m_stb_o = stb_i;
  assign m_we_o  = we_i;
  assign m_adr_o = adr_i;
  assign m_sel_o = sel_i;
  assign ack_o   = m_ack_i;

  secded_39_32_dec u_dec (
    .code_i     ({tgd_i, dat_i}),
    .data_o     (m_dat_o),  // uncorrectable data is written as decoded
    .syndrome_o (dec_syn),
    .err_o      (dec_err)
  );

  secded_39_32_enc u_enc (
    .data_i (m_dat_i),
    .code_o (rd_code)
  );

  assign dat_o = rd_code[EccDataWidth-1:0];
  assign tgd_o = rd_code[EccCodeWidth-1:EccDataWidth];  // fresh check bits

  // status only means something while a write is presented
  assign syndrome_o = wr_stb ? dec_syn : '0;
  assign err_o      = wr_stb ? dec_err : ECC_OK;

  // count once per acked write, stick at the top
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      corr_cnt_o   <= '0;
      uncorr_cnt_o <= '0;
    end else if (wr_stb && m_ack_i) begin
      if (err_o == ECC_CORRECTED && corr_cnt_o != CntMax) begin
        corr_cnt_o <= corr_cnt_o + 1'b1;
      end
      if (err_o == ECC_UNCORRECTABLE && uncorr_cnt_o != CntMax) begin
        uncorr_cnt_o <= uncorr_cnt_o + 1'b1;
      end
    end
  end

endmodule

/* rtl/secded_39_32_dec.sv */
// ********************
// SECDED (39,32) decoder, purely combinational
// returns corrected data, the syndrome and the error class
// ********************

`timescale 1ns/1ps

module secded_39_32_dec (
  input  logic [ecc_pkg::EccCodeWidth-1:0] code_i,      // {check, data}
  output logic [ecc_pkg::EccDataWidth-1:0] data_o,      // corrected data
  output logic [ecc_pkg::EccParWidth-1:0]  syndrome_o,  // recomputed ^ received
  output ecc_pkg::ecc_err_e                err_o        // error class
);

  import ecc_pkg::*;

  logic [EccDataWidth-1:0]                  rx_data;   // received data part
  logic [EccParWidth-1:0]                   rx_chk;    // received check part
  logic [EccParWidth-1:0]                   calc_chk;  // parity of received data
  logic [EccDataWidth-1:0][EccParWidth-1:0] col;       // H matrix column per data bit

  assign rx_data = code_i[EccDataWidth-1:0];
  assign rx_chk  = code_i[EccCodeWidth-1:EccDataWidth];

  // transpose the masks into per-bit columns
  for (genvar j = 0; j < EccDataWidth; j++) begin : g_col
    for (genvar k = 0; k < EccParWidth; k++) begin : g_bit
      assign col[j][k] = ecc_par_masks[k][j];
    end
  end

  always_comb begin
    for (int k = 0; k < EccParWidth; k++) begin
      calc_chk[k] = ^(rx_data & ecc_par_masks[k]);
    end
  end

  assign syndrome_o = calc_chk ^ rx_chk;

  // flip the data bit whose column matches the syndrome
  // a syndrome equal to a single check bit matches no column, data left as is
  always_comb begin
    data_o = rx_data;
    for (int j = 0; j < EccDataWidth; j++) begin
      if (syndrome_o == col[j]) begin
        data_o[j] = ~rx_data[j];
      end
    end
  end

  // Hsiao classification on syndrome weight
  always_comb begin
    if (syndrome_o == '0) begin
      err_o = ECC_OK;
    end else if (^syndrome_o) begin
      err_o = ECC_CORRECTED;       // odd weight, single error
    end else begin
      err_o = ECC_UNCORRECTABLE;   // even weight, double error
    end
  end

endmodule

/* rtl/secded_39_32_enc.sv */
// ********************
// SECDED (39,32) encoder, purely combinational
// check bits are placed above the unchanged data word
// ********************

`timescale 1ns/1ps

module secded_39_32_enc (
  input  logic [ecc_pkg::EccDataWidth-1:0] data_i,  // raw data
  output logic [ecc_pkg::EccCodeWidth-1:0] code_o   // {check, data}
);

  import ecc_pkg::*;

  logic [EccParWidth-1:0] par;  // freshly computed check bits

  // one parity tree per check bit
  always_comb begin
    for (int k = 0; k < EccParWidth; k++) begin
      par[k] = ^(data_i & ecc_par_masks[k]);
    end
  end

  assign code_o = {par, data_i};  // data passes straight through

endmodule

/* rtl/wb_pkg.sv */
// ********************
// Wishbone classic widths and memory slave states
// used by the bridge, the SRAM and the top level
// ********************

package wb_pkg;

  localparam int unsigned WbDataWidth = 32;  // bus data
  localparam int unsigned WbSelWidth  = WbDataWidth / 8;  // one select per byte
  localparam int unsigned WbAdrWidth  = 32;  // byte address, memory decodes bits 2 and up
  localparam int unsigned WbCntWidth  = 8;   // error counter width

  // memory slave handshake states
  typedef enum logic {
    S_IDLE = 1'b0,  // waiting for cyc & stb
    S_ACK  = 1'b1   // ack driven this cycle
  } wb_slv_state_e;

endpackage

/* rtl/ecc_pkg.sv */
// ********************
// Hsiao SECDED (39,32) code definitions shared by the encoder,
// the decoder and the bridge status outputs
// ********************

package ecc_pkg;

  localparam int unsigned EccDataWidth = 32;  // data bits per codeword
  localparam int unsigned EccParWidth  = 7;   // check bits
  localparam int unsigned EccCodeWidth = EccDataWidth + EccParWidth;  // check bits sit on top

  // check bit k = ^(data & ecc_par_masks[k])
  // each data column is a distinct weight-3 pattern over the 7 check bits,
  // taken in lexicographic order, so every column has odd weight
  localparam logic [EccParWidth-1:0][EccDataWidth-1:0] ecc_par_masks = {
    32'h69A4_6910,  // check bit 6
    32'hD552_5488,  // check bit 5
    32'hB2C9_3244,  // check bit 4
    32'h8E38_8E22,  // check bit 3
    32'h7E07_81E1,  // check bit 2
    32'h01FF_801F,  // check bit 1
    32'h0000_7FFF   // check bit 0
  };

  // decoder verdict for one codeword
  typedef enum logic [1:0] {
    ECC_OK            = 2'd0,  // syndrome zero
    ECC_CORRECTED     = 2'd1,  // odd syndrome, single flip repaired
    ECC_UNCORRECTABLE = 2'd2   // even nonzero syndrome
  } ecc_err_e;

endpackage
